//--- hdl/vga_timing_pkg.sv
package vga_timing_pkg;

	//////////////////////////////////////////////////
	// Coordinates and counts
	//////////////////////////////////////////////////

	// Screen coordinate or count within one phase
	typedef logic [9:0] coord_t;

	//////////////////////////////////////////////////
	// 640x480 timing
	//////////////////////////////////////////////////

	// Horizontal phases in clocks
	// 640 + 16 + 96 + 48 = 800 per line
	localparam coord_t h_active_last = 10'd639;
	localparam coord_t h_front_last  = 10'd15;
	localparam coord_t h_pulse_last  = 10'd95;
	localparam coord_t h_back_last   = 10'd47;

	// Vertical phases in lines
	// 480 + 10 + 2 + 33 = 525 per frame
	localparam coord_t v_active_last = 10'd479;
	localparam coord_t v_front_last  = 10'd9;
	localparam coord_t v_pulse_last  = 10'd1;
	localparam coord_t v_back_last   = 10'd32;

	//////////////////////////////////////////////////
	// Porch state machines
	//////////////////////////////////////////////////

	// Horizontal phase
	typedef enum logic [1:0] {
		h_active,
		h_front,
		h_pulse,
		h_back
	} h_state_t;

	// Vertical phase
	typedef enum logic [1:0] {
		v_active,
		v_front,
		v_pulse,
		v_back
	} v_state_t;

	// One beat per clock from the timing generator
	// x and y name the pixel to fetch for the next clock
	// Syncs are active low
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   hsync;
		logic   vsync;
	} vga_beat_t;

endpackage

//--- hdl/pixel_pkg.sv
package pixel_pkg;

	// One 8-bit output channel
	typedef logic [7:0] channel_t;

	// Stored pixel in RGB332
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// Pin colour, three full channels
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb888_t;

	// Frame geometry
	localparam vga_timing_pkg::coord_t screen_width  = 10'd640;
	localparam vga_timing_pkg::coord_t screen_height = 10'd480;
	localparam vga_timing_pkg::coord_t half_width    = 10'd320;
	localparam vga_timing_pkg::coord_t half_height   = 10'd240;

	// One entry per visible pixel
	localparam int unsigned fb_depth = int'(screen_width) * int'(screen_height);

	// Linear buffer address, y * 640 + x
	typedef logic [18:0] fb_addr_t;

	// Quadrant colours
	localparam rgb332_t colour_red    = '{red: 3'b111, green: 3'b000, blue: 2'b00};
	localparam rgb332_t colour_blue   = '{red: 3'b000, green: 3'b000, blue: 2'b11};
	localparam rgb332_t colour_green  = '{red: 3'b000, green: 3'b111, blue: 2'b00};
	localparam rgb332_t colour_yellow = '{red: 3'b111, green: 3'b111, blue: 2'b00};

	// Write port of the frame buffer
	typedef struct packed {
		vga_timing_pkg::coord_t x;
		vga_timing_pkg::coord_t y;
		rgb332_t                colour;
	} pixel_t;

endpackage

//--- hdl/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
	input  logic                      M10k_pll,
	input  logic                      reset,
	output vga_timing_pkg::vga_beat_t beat
);
	import vga_timing_pkg::*;

	// Phase counters
	coord_t   h_count;
	coord_t   v_count;

	// Porch state machines
	h_state_t h_state;
	v_state_t v_state;

	// Last count of the current phase and the phase after it
	coord_t   h_last;
	coord_t   v_last;
	h_state_t h_following;
	v_state_t v_following;

	// End of the current phase
	logic     h_wrap;
	logic     v_wrap;

	// Sync levels, registered by phase
	logic     hsync_q;
	logic     vsync_q;

	// High on the last clock of every line
	logic     line_done;

	//////////////////////////////////////////////////
	// Phase lengths
	//////////////////////////////////////////////////

	always_comb begin
		case (h_state)
			h_active: begin
				h_last      = h_active_last;
				h_following = h_front;
			end
			h_front: begin
				h_last      = h_front_last;
				h_following = h_pulse;
			end
			h_pulse: begin
				h_last      = h_pulse_last;
				h_following = h_back;
			end
			default: begin
				h_last      = h_back_last;
				h_following = h_active;
			end
		endcase
	end

	always_comb begin
		case (v_state)
			v_active: begin
				v_last      = v_active_last;
				v_following = v_front;
			end
			v_front: begin
				v_last      = v_front_last;
				v_following = v_pulse;
			end
			v_pulse: begin
				v_last      = v_pulse_last;
				v_following = v_back;
			end
			default: begin
				v_last      = v_back_last;
				v_following = v_active;
			end
		endcase
	end

	assign h_wrap = (h_count == h_last);
	assign v_wrap = (v_count == v_last);

	//////////////////////////////////////////////////
	// Horizontal machine
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_count   <= '0;
			h_state   <= h_active;
			hsync_q   <= 1'b1;
			line_done <= 1'b0;
		end else begin
			// Count through the phase, then step to the next one
			h_count <= h_wrap ? '0 : h_count + 10'd1;
			if (h_wrap)
				h_state <= h_following;
			// Low only while in the pulse phase
			hsync_q <= (h_state != h_pulse);
			// One count early so it lines up with the last clock of the line
			line_done <= (h_state == h_back) && (h_count == h_back_last - 10'd1);
		end
	end

	//////////////////////////////////////////////////
	// Vertical machine
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_count <= '0;
			v_state <= v_active;
			vsync_q <= 1'b1;
		end else begin
			// Lines advance only at the end of a line
			if (line_done) begin
				v_count <= v_wrap ? '0 : v_count + 10'd1;
				if (v_wrap)
					v_state <= v_following;
			end
			vsync_q <= (v_state != v_pulse);
		end
	end

	// Fetch coordinates, zero outside their own active phase
	assign beat.x      = (h_state == h_active) ? h_count : '0;
	assign beat.y      = (v_state == v_active) ? v_count : '0;
	assign beat.active = (h_state == h_active) && (v_state == v_active);
	assign beat.hsync  = hsync_q;
	assign beat.vsync  = vsync_q;

endmodule

//--- hdl/frame_writer.sv
`timescale 1ns/1ns

module frame_writer (
	input  logic              M10k_pll,
	input  logic              reset,
	output pixel_pkg::pixel_t wr_pixel,
	output logic              wr_en
);
	import vga_timing_pkg::*;
	import pixel_pkg::*;

	// Raster sweep position
	coord_t  x_count;
	coord_t  y_count;

	// Sweep wrap points
	logic    at_line_end;
	logic    at_frame_end;

	// Pattern colour at the sweep position
	rgb332_t quad_colour;

	assign at_line_end  = (x_count == screen_width - 10'd1);
	assign at_frame_end = (y_count == screen_height - 10'd1);

	// Left half red or green, right half blue or yellow
	always_comb begin
		if (x_count < half_width)
			quad_colour = (y_count < half_height) ? colour_red : colour_green;
		else
			quad_colour = (y_count < half_height) ? colour_blue : colour_yellow;
	end

	// Sweep in raster order, forever
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			x_count <= '0;
			y_count <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en   <= 1'b1;
			x_count <= at_line_end ? '0 : x_count + 10'd1;
			if (at_line_end)
				y_count <= at_frame_end ? '0 : y_count + 10'd1;
		end
	end

	// Write port stage
	always_ff @(posedge M10k_pll) begin
		wr_pixel <= '{x: x_count, y: y_count, colour: quad_colour};
	end

endmodule

//--- hdl/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer (
	input  logic                   M10k_pll,
	input  pixel_pkg::pixel_t      wr_pixel,
	input  logic                   wr_en,
	input  vga_timing_pkg::coord_t rd_x,
	input  vga_timing_pkg::coord_t rd_y,
	output pixel_pkg::rgb332_t     rd_colour
);
	import pixel_pkg::*;

	// One entry per visible pixel
	rgb332_t  mem [fb_depth];

	// Linear addresses of both ports
	fb_addr_t wr_addr;
	fb_addr_t rd_addr;

	// Row major, y * 640 + x
	assign wr_addr = fb_addr_t'(wr_pixel.y) * fb_addr_t'(screen_width)
		+ fb_addr_t'(wr_pixel.x);
	assign rd_addr = fb_addr_t'(rd_y) * fb_addr_t'(screen_width)
		+ fb_addr_t'(rd_x);

	// Write port
	always_ff @(posedge M10k_pll) begin
		if (wr_en)
			mem[wr_addr] <= wr_pixel.colour;
	end

	// Read port with one clock of latency
	// Old data on a same-address collision
	always_ff @(posedge M10k_pll) begin
		rd_colour <= mem[rd_addr];
	end

endmodule

//--- hdl/pixel_out.sv
`timescale 1ns/1ns

module pixel_out (
	input  logic                      M10k_pll,
	input  logic                      reset,
	input  vga_timing_pkg::vga_beat_t beat,
	input  pixel_pkg::rgb332_t        colour,
	output pixel_pkg::rgb888_t        vga_rgb,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank_n
);
	import pixel_pkg::*;

	// Beat control fields, one clock late to meet the read data
	logic    active_d;
	logic    hsync_d;
	logic    vsync_d;

	// Read colour widened to full channels
	rgb888_t wide;

	//////////////////////////////////////////////////
	// Colour expansion
	//////////////////////////////////////////////////

	// Bit replication so all ones give ff and all zeros give 00
	always_comb begin
		wide.red   = {colour.red, colour.red, colour.red[2:1]};
		wide.green = {colour.green, colour.green, colour.green[2:1]};
		wide.blue  = {4{colour.blue}};
	end

	//////////////////////////////////////////////////
	// Alignment and pin registers
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
			vga_rgb  <= '0;
			hsync    <= 1'b1;
			vsync    <= 1'b1;
			blank_n  <= 1'b1;
		end else begin
			active_d <= beat.active;
			hsync_d  <= beat.hsync;
			vsync_d  <= beat.vsync;
			// Black outside the active area
			vga_rgb  <= active_d ? wide : '0;
			hsync    <= hsync_d;
			vsync    <= vsync_d;
			// Blank during either sync pulse
			blank_n  <= hsync_d & vsync_d;
		end
	end

endmodule

//--- hdl/vga_top.sv
`timescale 1ns/1ns

module vga_top (
	input  logic               M10k_pll,
	input  logic               reset,
	output pixel_pkg::rgb888_t vga_rgb,
	output logic               hsync,
	output logic               vsync,
	output logic               blank_n
);
	import vga_timing_pkg::*;
	import pixel_pkg::*;

	// Timing beat to the buffer and the output stage
	vga_beat_t beat;

	// Pattern write port
	pixel_t    wr_pixel;
	logic      wr_en;

	// Pixel read back for the current beat
	rgb332_t   rd_colour;

	// Porch and sync generator
	vga_timing i_vga_timing (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.beat     (beat)
	);

	// Quadrant pattern fill
	frame_writer i_frame_writer (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.wr_pixel (wr_pixel),
		.wr_en    (wr_en)
	);

	// Pixel memory
	frame_buffer i_frame_buffer (
		.M10k_pll  (M10k_pll),
		.wr_pixel  (wr_pixel),
		.wr_en     (wr_en),
		.rd_x      (beat.x),
		.rd_y      (beat.y),
		.rd_colour (rd_colour)
	);

	// Pin stage
	pixel_out i_pixel_out (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.beat     (beat),
		.colour   (rd_colour),
		.vga_rgb  (vga_rgb),
		.hsync    (hsync),
		.vsync    (vsync),
		.blank_n  (blank_n)
	);

endmodule

//--- sim/vga_model.svh
`ifndef vga_model_svh
`define vga_model_svh

//////////////////////////////////////////////////
// Raster rules at the pins
//////////////////////////////////////////////////

// 800 clocks per line, hsync low for 96
localparam int line_clocks  = 800;
localparam int hs_start     = 656;
localparam int hs_clocks    = 96;
// 525 lines per frame, vsync low for 2
localparam int frame_lines  = 525;
localparam int vs_start     = 490;
localparam int vs_lines     = 2;
localparam int visible_w    = 640;
localparam int visible_h    = 480;
localparam int frame_clocks = line_clocks * frame_lines;
localparam int fill_clocks  = visible_w * visible_h;
// First fetch reaches the pins two clocks after release
localparam int pin_delay    = 2;

// Quadrant colours as seen on the pins
localparam rgb888_t pin_red    = 24'hff0000;
localparam rgb888_t pin_blue   = 24'h0000ff;
localparam rgb888_t pin_green  = 24'h00ff00;
localparam rgb888_t pin_yellow = 24'hffff00;

logic [31:0] lfsr_state;

// Clocks since release, pixel position, position one clock back
int   model_clocks;
int   model_h;
int   model_v;
int   sync_h;
int   sync_v;
logic sync_valid;

// Taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

task automatic model_restart();
	model_clocks = 0;
	model_h      = 0;
	model_v      = 0;
	sync_valid   = 1'b0;
endtask

// Syncs follow the pixel position one clock late
task automatic model_advance();
	if (model_clocks > pin_delay) begin
		sync_h     = model_h;
		sync_v     = model_v;
		sync_valid = 1'b1;
		if (model_h == line_clocks - 1) begin
			model_h = 0;
			model_v = (model_v == frame_lines - 1) ? 0 : model_v + 1;
		end else begin
			model_h = model_h + 1;
		end
	end
endtask

function automatic logic model_hsync();
	return !(sync_valid && sync_h >= hs_start && sync_h < hs_start + hs_clocks);
endfunction

function automatic logic model_vsync();
	return !(sync_valid && sync_v >= vs_start && sync_v < vs_start + vs_lines);
endfunction

function automatic logic model_active();
	return model_clocks >= pin_delay && model_h < visible_w && model_v < visible_h;
endfunction

function automatic rgb888_t model_colour();
	if (model_h < visible_w / 2)
		return (model_v < visible_h / 2) ? pin_red : pin_green;
	return (model_v < visible_h / 2) ? pin_blue : pin_yellow;
endfunction

task automatic check_colour(input string name, input rgb888_t expected, input rgb888_t actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %h actual %h", name, expected, actual);
		stop_with_failure();
	end
endtask

task automatic check_level(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %b actual %b", name, expected, actual);
		stop_with_failure();
	end
endtask

`endif

//--- sim/vga_tb.sv
`timescale 1ns/1ns

module vga_tb;
	import pixel_pkg::*;

	// DUT pins
	logic    M10k_pll;
	logic    reset;
	rgb888_t vga_rgb;
	logic    hsync;
	logic    vsync;
	logic    blank_n;

	// Reset and run sequences
	localparam int run_count = 4;
	// Extra run length on top of one frame, up to two more
	localparam logic [31:0] extra_span = 32'(2 * 420000 + 1);

	logic [31:0] rand_value;
	int          run_len;

	vga_top i_dut (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.vga_rgb  (vga_rgb),
		.hsync    (hsync),
		.vsync    (vsync),
		.blank_n  (blank_n)
	);

	// 4 ns clock
	always #2 M10k_pll = ~M10k_pll;

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	`include "vga_model.svh"

	//////////////////////////////////////////////////
	// Per-clock stepping and checks
	//////////////////////////////////////////////////

	task automatic check_pins();
		string test;
		test = (reset || model_clocks < pin_delay) ? "reset state" : "raster";
		check_level({test, " hsync"}, model_hsync(), hsync);
		check_level({test, " vsync"}, model_vsync(), vsync);
		// Blank whenever either sync is low
		check_level({test, " blank_n"}, model_hsync() & model_vsync(), blank_n);
		if (!model_active())
			check_colour({test, " blanking"}, '0, vga_rgb);
		else if (model_clocks >= fill_clocks)
			check_colour("quadrant colour", model_colour(), vga_rgb);
	endtask

	// Falling edge, pins settled since the rising edge
	task automatic tick();
		@(negedge M10k_pll);
		if (reset) begin
			model_restart();
		end else begin
			model_clocks = model_clocks + 1;
			model_advance();
		end
		check_pins();
	endtask

	// One LFSR step per bit
	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic apply_reset(input int cycles);
		reset = 1'b1;
		repeat (cycles) tick();
		reset = 1'b0;
	endtask

	// Wait for the first sync pulse of a run
	task automatic wait_for_sync(input bit vertical, input int limit);
		int waited;
		waited = 0;
		while ((vertical ? vsync : hsync) !== 1'b0) begin
			if (waited >= limit) begin
				$display("Timeout: %s pulse never came after reset release",
					vertical ? "vsync" : "hsync");
				stop_with_failure();
			end else begin
				tick();
				waited = waited + 1;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		M10k_pll   = 1'b0;
		reset      = 1'b1;
		lfsr_state = 32'hde12ac0e;
		model_restart();
		apply_reset(16);
		for (int run = 0; run < run_count; run++) begin
			// Mid-frame reset of 1 to 20 clocks
			if (run > 0) begin
				draw_bits(5, rand_value);
				apply_reset(1 + int'(rand_value % 32'd20));
			end
			// Between one and three frames
			draw_bits(20, rand_value);
			run_len = frame_clocks + int'(rand_value % extra_span);
			wait_for_sync(1'b0, 2 * line_clocks);
			wait_for_sync(1'b1, frame_clocks + line_clocks);
			while (model_clocks < run_len)
				tick();
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- flist.f
+incdir+sim
hdl/vga_timing_pkg.sv
hdl/pixel_pkg.sv
hdl/vga_timing.sv
hdl/frame_writer.sv
hdl/frame_buffer.sv
hdl/pixel_out.sv
hdl/vga_top.sv
sim/vga_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = vga_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulator is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
